// File: common/eth_stim_defines.svh
`ifndef ETH_STIM_DEFINES_SVH
`define ETH_STIM_DEFINES_SVH

////////////////////////////////////////////////////////////
// Station addresses
////////////////////////////////////////////////////////////

`define FPGA_MAC        48'h00D0_0800_0002
`define HOST_MAC        48'h0024_7EDF_CA5E
`define FPGA_IP         32'hC0A8_006E   // 192.168.0.110
`define HOST_IP         32'hC0A8_0077   // 192.168.0.119
`define UDP_PORT        16'd8080

// Marks an AD data payload
`define ETH_FLAG        32'hEEBA_EEBA

////////////////////////////////////////////////////////////
// AXI write side
////////////////////////////////////////////////////////////

`define AXI_ADDR_W      32
`define AXI_DATA_W      32

`define ADDR_AD2ETH     32'h1000_0000
`define ADDR_SUMOFFSET  32'h0000_1000

`define BURST_BEATS     32

////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////

`define FRAMES_PER_KIND 5
`define GAP_CYCLES      136   // Idle cycles after each frame
`define IDLE_TIMEOUT    1024

`endif

// File: common/eth_frame_pkg.sv
`include "eth_stim_defines.svh"

package eth_frame_pkg;

	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [15:0] ethertype;
	} eth_hdr_t;

	typedef struct packed {
		logic [15:0] ver_tos;     // Version, IHL, TOS
		logic [15:0] total_len;
		logic [15:0] ident;
		logic [15:0] flags_frag;
		logic [15:0] ttl_proto;
		logic [15:0] hdr_sum;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
	} ipv4_hdr_t;

	typedef struct packed {
		eth_hdr_t     eth;
		ipv4_hdr_t    ip;
		logic [15:0]  src_port;
		logic [15:0]  dst_port;
		logic [15:0]  udp_len;
		logic [15:0]  udp_sum;
		logic [31:0]  flag;
		logic [127:0] payload;
		logic [31:0]  fcs;
	} udp_frame_t;

	typedef struct packed {
		eth_hdr_t     eth;
		logic [15:0]  htype;
		logic [15:0]  ptype;
		logic [7:0]   hlen;
		logic [7:0]   plen;
		logic [15:0]  oper;
		logic [47:0]  sender_mac;
		logic [31:0]  sender_ip;
		logic [47:0]  target_mac;
		logic [31:0]  target_ip;
		logic [143:0] pad;        // Up to minimum frame size
		logic [31:0]  fcs;
	} arp_frame_t;

	typedef struct packed {
		eth_hdr_t     eth;
		ipv4_hdr_t    ip;
		logic [15:0]  type_code;
		logic [15:0]  icmp_sum;
		logic [15:0]  ident;
		logic [15:0]  seq;
		logic [255:0] payload;
		logic [31:0]  fcs;
	} icmp_frame_t;

	typedef enum logic [1:0] {UDP, ARP, ICMP} frame_kind_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} stream_beat_t;

	////////////////////////////////////////////////////////////
	// Frame templates
	////////////////////////////////////////////////////////////

	localparam udp_frame_t UDP_TEMPLATE = '{
		eth:      '{`FPGA_MAC, `HOST_MAC, 16'h0800},
		ip:       '{16'h4500, 16'd48, 16'h0012, 16'h4000,
		            16'h8011, 16'h0000, `HOST_IP, `FPGA_IP},
		src_port: `UDP_PORT,
		dst_port: `UDP_PORT,
		udp_len:  16'd28,
		udp_sum:  16'h0000,
		flag:     `ETH_FLAG,
		payload:  128'h1234_5611_1134_5678_1234_5678_AABB_CCDD,
		fcs:      32'hCFD9_3530
	};

	// Broadcast who-has for the FPGA IP
	localparam arp_frame_t ARP_TEMPLATE = '{
		eth:        '{48'hFFFF_FFFF_FFFF, `HOST_MAC, 16'h0806},
		htype:      16'h0001,
		ptype:      16'h0800,
		hlen:       8'd6,
		plen:       8'd4,
		oper:       16'h0001,
		sender_mac: `HOST_MAC,
		sender_ip:  `HOST_IP,
		target_mac: 48'h0,
		target_ip:  `FPGA_IP,
		pad:        144'h0,
		fcs:        32'h59FB_0258
	};

	localparam icmp_frame_t ICMP_TEMPLATE = '{
		eth:       '{`FPGA_MAC, `HOST_MAC, 16'h0800},
		ip:        '{16'h4500, 16'h003C, 16'h71A0, 16'h0000,
		             16'h8001, 16'h0000, `HOST_IP, `FPGA_IP},
		type_code: 16'h0800,   // Echo request
		icmp_sum:  16'h4D56,
		ident:     16'h0001,
		seq:       16'h0005,
		payload:   {128'h6162_6364_6566_6768_696A_6B6C_6D6E_6F70,
		            128'h7172_7374_7576_7761_6263_6465_6667_6869},
		fcs:       32'hC034_2A1A
	};

endpackage

// File: common/axi_wr_pkg.sv
`include "eth_stim_defines.svh"

package axi_wr_pkg;

	// Write address, fixed INCR burst of 32-bit words
	typedef struct packed {
		logic [`AXI_ADDR_W-1:0] addr;
		logic [7:0]             len;
	} aw_t;

	typedef struct packed {
		logic [`AXI_DATA_W-1:0]   data;
		logic [`AXI_DATA_W/8-1:0] strb;
		logic                     last;
	} w_t;

	typedef struct packed {
		logic [1:0] resp;   // OKAY, EXOKAY, SLVERR, DECERR
	} b_t;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA,
		RESP
	} wr_state_t;

endpackage

// File: frame_gen/frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer #(
	parameter type frame_t = logic [7:0],
	parameter frame_t FRAME = '0
) (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  logic                        start,
	output eth_frame_pkg::stream_beat_t beat,
	output logic                        valid,
	input  logic                        ready,
	output logic                        done
);

	localparam int FRAME_BITS  = $bits(frame_t);
	localparam int FRAME_BYTES = FRAME_BITS / 8;
	localparam int CNT_W       = $clog2(FRAME_BYTES + 1);

	logic [FRAME_BITS-1:0] shift_q;
	logic [CNT_W-1:0]      left_q;    // Bytes not yet accepted
	logic                  accept;

	assign accept    = valid && ready;
	assign valid     = (left_q != '0);
	assign beat.data = shift_q[FRAME_BITS-1 -: 8];   // MSB first
	assign beat.last = (left_q == CNT_W'(1));

	always_ff @(posedge sys_clk) begin
		if (start) begin
			shift_q <= FRAME;
		end else if (accept) begin
			shift_q <= shift_q << 8;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			left_q <= '0;
			done   <= 1'b0;
		end else begin
			done <= accept && beat.last;
			if (start) begin
				left_q <= CNT_W'(FRAME_BYTES);
			end else if (accept) begin
				left_q <= left_q - CNT_W'(1);
			end
		end
	end

endmodule

// File: frame_gen/frame_sequencer.sv
`timescale 1ns/1ps
`include "eth_stim_defines.svh"

module frame_sequencer (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	output eth_frame_pkg::stream_beat_t rx,
	output logic                        rx_valid,
	input  logic                        rx_ready
);

	localparam int CNT_W = $clog2(`FRAMES_PER_KIND);
	localparam int GAP_W = $clog2(`GAP_CYCLES + 1);

	eth_frame_pkg::frame_kind_t kind_q;
	eth_frame_pkg::frame_kind_t kind_next;
	logic [CNT_W-1:0]           count_q;
	logic [GAP_W-1:0]           gap_q;
	logic                       first_q;
	logic                       start;
	logic                       done;
	logic [2:0]                 sel;

	// Per serializer, indexed by frame kind
	eth_frame_pkg::stream_beat_t beat [3];
	logic [2:0]                  valid_vec;
	logic [2:0]                  ready_vec;
	logic [2:0]                  start_vec;
	logic [2:0]                  done_vec;

	assign start = first_q || (gap_q == GAP_W'(1));
	assign sel   = 3'b001 << kind_q;

	assign start_vec = {3{start}} & sel;
	assign ready_vec = {3{rx_ready}} & sel;

	assign rx       = beat[kind_q];
	assign rx_valid = valid_vec[kind_q];
	assign done     = done_vec[kind_q];

	always_comb begin
		case (kind_q)
			eth_frame_pkg::UDP: kind_next = eth_frame_pkg::ARP;
			eth_frame_pkg::ARP: kind_next = eth_frame_pkg::ICMP;
			default:            kind_next = eth_frame_pkg::UDP;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Kind rotation and inter-frame gap
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			kind_q  <= eth_frame_pkg::UDP;
			count_q <= '0;
			gap_q   <= '0;
			first_q <= 1'b1;
		end else begin
			first_q <= 1'b0;
			if (done) begin
				// Done and start cycles count toward the gap
				gap_q <= GAP_W'(`GAP_CYCLES - 1);
				if (count_q == CNT_W'(`FRAMES_PER_KIND - 1)) begin
					count_q <= '0;
					kind_q  <= kind_next;
				end else begin
					count_q <= count_q + CNT_W'(1);
				end
			end else if (gap_q != '0) begin
				gap_q <= gap_q - GAP_W'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// One serializer per frame kind
	////////////////////////////////////////////////////////////

	frame_serializer #(
		.frame_t (eth_frame_pkg::udp_frame_t),
		.FRAME   (eth_frame_pkg::UDP_TEMPLATE)
	) u_udp (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.start   (start_vec[0]),
		.beat    (beat[0]),
		.valid   (valid_vec[0]),
		.ready   (ready_vec[0]),
		.done    (done_vec[0])
	);

	frame_serializer #(
		.frame_t (eth_frame_pkg::arp_frame_t),
		.FRAME   (eth_frame_pkg::ARP_TEMPLATE)
	) u_arp (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.start   (start_vec[1]),
		.beat    (beat[1]),
		.valid   (valid_vec[1]),
		.ready   (ready_vec[1]),
		.done    (done_vec[1])
	);

	frame_serializer #(
		.frame_t (eth_frame_pkg::icmp_frame_t),
		.FRAME   (eth_frame_pkg::ICMP_TEMPLATE)
	) u_icmp (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.start   (start_vec[2]),
		.beat    (beat[2]),
		.valid   (valid_vec[2]),
		.ready   (ready_vec[2]),
		.done    (done_vec[2])
	);

endmodule

// File: axi_wr/axi_burst_writer.sv
`timescale 1ns/1ps
`include "eth_stim_defines.svh"

module axi_burst_writer (
	input  logic            sys_clk,
	input  logic            sys_rst,
	output axi_wr_pkg::aw_t aw,
	output logic            aw_valid,
	input  logic            aw_ready,
	output axi_wr_pkg::w_t  w,
	output logic            w_valid,
	input  logic            w_ready,
	input  axi_wr_pkg::b_t  b,
	input  logic            b_valid,
	output logic            b_ready
);

	localparam int TIMER_W = $clog2(`IDLE_TIMEOUT);
	localparam int BEAT_W  = $clog2(`BURST_BEATS);
	localparam int DATA_W  = `AXI_DATA_W;

	axi_wr_pkg::wr_state_t state_q;
	logic [TIMER_W-1:0]    idle_q;
	logic                  sum_pending_q;   // Next write is the sum word
	logic [BEAT_W-1:0]     beat_q;
	logic [DATA_W-1:0]     word_q;          // Running count across bursts
	logic [DATA_W-1:0]     sum_q;

	assign aw_valid = (state_q == axi_wr_pkg::ADDR);
	assign w_valid  = (state_q == axi_wr_pkg::DATA);
	assign b_ready  = (state_q == axi_wr_pkg::RESP);

	////////////////////////////////////////////////////////////
	// Channel payloads
	////////////////////////////////////////////////////////////

	always_comb begin
		aw.addr = `ADDR_AD2ETH;
		aw.len  = 8'(`BURST_BEATS - 1);
		w.data  = word_q;
		w.strb  = '1;
		w.last  = (beat_q == BEAT_W'(`BURST_BEATS - 1));
		if (sum_pending_q) begin
			aw.addr = `ADDR_AD2ETH + `ADDR_SUMOFFSET;
			aw.len  = 8'd0;
			w.data  = sum_q;
			w.last  = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Write FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q       <= axi_wr_pkg::IDLE;
			idle_q        <= '0;
			sum_pending_q <= 1'b0;
			beat_q        <= '0;
			word_q        <= '0;
		end else begin
			case (state_q)
				axi_wr_pkg::IDLE: begin
					idle_q <= idle_q + TIMER_W'(1);
					if (idle_q == TIMER_W'(`IDLE_TIMEOUT - 1)) begin
						idle_q  <= '0;
						state_q <= axi_wr_pkg::ADDR;
					end
				end
				axi_wr_pkg::ADDR: begin
					if (aw_ready) begin
						beat_q  <= '0;
						state_q <= axi_wr_pkg::DATA;
					end
				end
				axi_wr_pkg::DATA: begin
					if (w_ready) begin
						if (!sum_pending_q) begin
							word_q <= word_q + DATA_W'(1);
							beat_q <= beat_q + BEAT_W'(1);
						end
						if (w.last) begin
							state_q <= axi_wr_pkg::RESP;
						end
					end
				end
				default: begin
					if (b_valid) begin
						if (sum_pending_q) begin
							sum_pending_q <= 1'b0;
							state_q       <= axi_wr_pkg::IDLE;
						end else begin
							sum_pending_q <= 1'b1;
							state_q       <= axi_wr_pkg::ADDR;
						end
					end
				end
			endcase
		end
	end

	// Burst sum, restarted with each data burst
	always_ff @(posedge sys_clk) begin
		if (aw_valid && aw_ready && !sum_pending_q) begin
			sum_q <= '0;
		end else if (w_valid && w_ready && !sum_pending_q) begin
			sum_q <= sum_q + word_q;
		end
	end

endmodule

// File: hw/eth_stim_top.sv
`timescale 1ns/1ps

module eth_stim_top (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	// Receive byte stream
	output eth_frame_pkg::stream_beat_t rx,
	output logic                        rx_valid,
	input  logic                        rx_ready,
	// AXI write master
	output axi_wr_pkg::aw_t             aw,
	output logic                        aw_valid,
	input  logic                        aw_ready,
	output axi_wr_pkg::w_t              w,
	output logic                        w_valid,
	input  logic                        w_ready,
	input  axi_wr_pkg::b_t              b,
	input  logic                        b_valid,
	output logic                        b_ready
);

	frame_sequencer u_frame_sequencer (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_ready (rx_ready)
	);

	axi_burst_writer u_axi_burst_writer (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready)
	);

endmodule

// File: tb/tb_eth_stim_top.sv
`timescale 1ns/1ps
`include "eth_stim_defines.svh"

module tb_eth_stim_top;

	localparam int RUN_TIMEOUT   = 20000;   // Cycles for the whole run
	localparam int FRAMES_TO_RUN = 16;
	localparam int PAIRS_TO_RUN  = 2;

	logic                        sys_clk;
	logic                        sys_rst;
	eth_frame_pkg::stream_beat_t rx;
	logic                        rx_valid;
	logic                        rx_ready;
	axi_wr_pkg::aw_t             aw;
	logic                        aw_valid;
	logic                        aw_ready;
	axi_wr_pkg::w_t              w;
	logic                        w_valid;
	logic                        w_ready;
	axi_wr_pkg::b_t              b;
	logic                        b_valid;
	logic                        b_ready;

	// Monitor state
	int                          frames_done;
	int                          byte_idx;
	int                          gap_cnt;
	logic                        in_gap;
	int                          writes_done;   // aw transfers so far
	int                          pairs_done;
	int                          beat_idx;
	logic                        write_is_sum;
	logic                        write_open;
	logic                        sum_due;
	logic [31:0]                 word_cnt;
	logic [31:0]                 burst_sum;
	logic                        rx_stalled;
	logic                        aw_stalled;
	logic                        w_stalled;
	eth_frame_pkg::stream_beat_t rx_held;
	axi_wr_pkg::aw_t             aw_held;
	axi_wr_pkg::w_t              w_held;
	logic                        w_last_fire;
	logic                        b_fire;
	int                          b_delay;       // Slave response countdown, -1 when idle

	eth_stim_top DUT (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_ready (rx_ready),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		$display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_failure(string what);
		$display("Check failed: %s", what);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_timeout(string what);
		$display("Timeout: %s did not happen within %0d cycles", what, RUN_TIMEOUT);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on a timeout");
	endtask

	////////////////////////////////////////////////////////////
	// Reference model of the frame stream
	////////////////////////////////////////////////////////////

	function automatic eth_frame_pkg::frame_kind_t expected_kind(int frame_num);
		case ((frame_num / `FRAMES_PER_KIND) % 3)
			0:       return eth_frame_pkg::UDP;
			1:       return eth_frame_pkg::ARP;
			default: return eth_frame_pkg::ICMP;
		endcase
	endfunction

	function automatic int frame_len(eth_frame_pkg::frame_kind_t kind);
		case (kind)
			eth_frame_pkg::UDP: return 66;
			eth_frame_pkg::ARP: return 64;
			default:            return 78;
		endcase
	endfunction

	// Templates go out most significant byte first
	function automatic logic [7:0] expected_byte(eth_frame_pkg::frame_kind_t kind, int idx);
		eth_frame_pkg::udp_frame_t  udp;
		eth_frame_pkg::arp_frame_t  arp;
		eth_frame_pkg::icmp_frame_t icmp;
		int                         pos;
		udp  = eth_frame_pkg::UDP_TEMPLATE;
		arp  = eth_frame_pkg::ARP_TEMPLATE;
		icmp = eth_frame_pkg::ICMP_TEMPLATE;
		pos  = 8 * (frame_len(kind) - 1 - idx);
		case (kind)
			eth_frame_pkg::UDP: return udp[pos +: 8];
			eth_frame_pkg::ARP: return arp[pos +: 8];
			default:            return icmp[pos +: 8];
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Channel monitors
	////////////////////////////////////////////////////////////

	task automatic check_rx_channel();
		eth_frame_pkg::frame_kind_t kind;
		logic [7:0]                 exp_byte;
		logic                       exp_last;
		kind = expected_kind(frames_done);
		if (rx_stalled) begin
			assert (rx_valid) else report_failure("rx_valid dropped before its transfer");
			assert (rx == rx_held) else report_mismatch("rx_hold", 64'(rx_held), 64'(rx));
		end
		if (rx_valid) begin
			if (in_gap) begin
				assert (gap_cnt == `GAP_CYCLES)
					else report_mismatch("frame_gap", 64'(`GAP_CYCLES), 64'(gap_cnt));
				in_gap = 1'b0;
			end
			if (rx_ready) begin
				exp_byte = expected_byte(kind, byte_idx);
				exp_last = (byte_idx == frame_len(kind) - 1);
				assert (rx.data == exp_byte) else report_mismatch(
					$sformatf("frame %0d byte %0d", frames_done, byte_idx),
					64'(exp_byte), 64'(rx.data));
				assert (rx.last == exp_last) else report_mismatch(
					$sformatf("frame %0d last at byte %0d", frames_done, byte_idx),
					64'(exp_last), 64'(rx.last));
				byte_idx++;
				if (rx.last) begin
					frames_done++;
					byte_idx = 0;
					in_gap   = 1'b1;
					gap_cnt  = 0;
				end
			end
		end else begin
			assert (byte_idx == 0) else report_failure("rx_valid dropped inside a frame");
			if (in_gap) gap_cnt++;
		end
		rx_stalled = rx_valid && !rx_ready;
		rx_held    = rx;
	endtask

	task automatic check_aw_channel();
		logic [31:0] exp_addr;
		logic [7:0]  exp_len;
		if (aw_stalled) begin
			assert (aw_valid) else report_failure("aw_valid dropped before its transfer");
			assert (aw == aw_held) else report_mismatch("aw_hold", 64'(aw_held), 64'(aw));
		end
		if (sum_due) begin
			assert (aw_valid) else report_failure("sum write did not follow the burst response");
			sum_due = 1'b0;
		end
		if (aw_valid && aw_ready) begin
			write_is_sum = ((writes_done % 2) == 1);
			exp_addr = write_is_sum ? `ADDR_AD2ETH + `ADDR_SUMOFFSET : `ADDR_AD2ETH;
			exp_len  = write_is_sum ? 8'd0 : 8'(`BURST_BEATS - 1);
			assert (aw.addr == exp_addr)
				else report_mismatch("aw_addr", 64'(exp_addr), 64'(aw.addr));
			assert (aw.len == exp_len)
				else report_mismatch("aw_len", 64'(exp_len), 64'(aw.len));
			if (!write_is_sum) burst_sum = '0;
			writes_done++;
			beat_idx = 0;
		end
		aw_stalled = aw_valid && !aw_ready;
		aw_held    = aw;
	endtask

	task automatic check_w_channel();
		logic [31:0] exp_data;
		logic        exp_last;
		if (w_stalled) begin
			assert (w_valid) else report_failure("w_valid dropped before its transfer");
			assert (w == w_held) else report_mismatch("w_hold", 64'(w_held), 64'(w));
		end
		if (w_valid && w_ready) begin
			assert (write_open) else report_failure("write data beat without an open write");
			exp_data = write_is_sum ? burst_sum : word_cnt;
			exp_last = write_is_sum ? 1'b1 : (beat_idx == `BURST_BEATS - 1);
			assert (w.data == exp_data) else report_mismatch(
				$sformatf("write %0d beat %0d data", writes_done, beat_idx),
				64'(exp_data), 64'(w.data));
			assert (w.strb == 4'hF) else report_mismatch("w_strb", 64'hF, 64'(w.strb));
			assert (w.last == exp_last) else report_mismatch(
				$sformatf("write %0d beat %0d last", writes_done, beat_idx),
				64'(exp_last), 64'(w.last));
			if (!write_is_sum) begin
				burst_sum = burst_sum + word_cnt;   // Wraps at 2^32
				word_cnt  = word_cnt + 32'd1;
			end
			beat_idx++;
		end
		w_last_fire = w_valid && w_ready && w.last;
		w_stalled   = w_valid && !w_ready;
		w_held      = w;
	endtask

	task automatic check_b_channel();
		b_fire = b_valid && b_ready;
		if (b_fire) begin
			if (write_is_sum) pairs_done++;
			else sum_due = 1'b1;
		end
	endtask

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			frames_done = 0;
			byte_idx    = 0;
			gap_cnt     = 0;
			in_gap      = 1'b0;
			writes_done = 0;
			pairs_done  = 0;
			beat_idx    = 0;
			write_is_sum = 1'b0;
			sum_due     = 1'b0;
			word_cnt    = '0;
			burst_sum   = '0;
			rx_stalled  = 1'b0;
			aw_stalled  = 1'b0;
			w_stalled   = 1'b0;
			w_last_fire = 1'b0;
			b_fire      = 1'b0;
		end else begin
			check_rx_channel();
			check_aw_channel();
			check_w_channel();
			check_b_channel();
		end
	end

	// Open from the aw transfer until its response
	always @(posedge sys_clk) begin
		if (sys_rst) write_open <= 1'b0;
		else if (aw_valid && aw_ready) write_open <= 1'b1;
		else if (b_valid && b_ready) write_open <= 1'b0;
	end

	assert property (@(posedge sys_clk)
		$past(sys_rst) |-> !(rx_valid || aw_valid || w_valid || b_ready))
		else report_mismatch("reset_idle", 64'd0, 64'({rx_valid, aw_valid, w_valid, b_ready}));

	assert property (@(posedge sys_clk) disable iff (sys_rst) aw_valid |-> !write_open)
		else report_failure("aw_valid raised before the previous write response");

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_inputs();
		rx_ready = ($urandom_range(0, 3) != 0);
		aw_ready = ($urandom_range(0, 1) != 0);
		w_ready  = ($urandom_range(0, 3) != 0);
		if (b_fire) b_valid = 1'b0;
		if (w_last_fire) begin
			b_delay = int'($urandom_range(0, 7));
		end else if (b_delay > 0) begin
			b_delay--;
		end
		if (b_delay == 0) begin
			b.resp  = 2'($urandom_range(0, 3));   // Any code, OKAY to DECERR
			b_valid = 1'b1;
			b_delay = -1;
		end
	endtask

	initial begin
		int          cycles;
		int unsigned seed_init;
		seed_init = $urandom(65811);
		sys_rst   = 1'b1;
		rx_ready  = 1'b0;
		aw_ready  = 1'b0;
		w_ready   = 1'b0;
		b         = '0;
		b_valid   = 1'b0;
		b_delay   = -1;
		repeat (10) @(negedge sys_clk);
		sys_rst = 1'b0;
		cycles  = 0;
		while (!(frames_done >= FRAMES_TO_RUN && pairs_done >= PAIRS_TO_RUN) &&
			cycles < RUN_TIMEOUT) begin
			@(negedge sys_clk);
			drive_inputs();
			cycles++;
		end
		if (frames_done >= FRAMES_TO_RUN && pairs_done >= PAIRS_TO_RUN) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			report_timeout("16 frames and two complete write pairs");
		end
	end

endmodule

// File: eth_stim_gen.f
+incdir+common
common/eth_frame_pkg.sv
common/axi_wr_pkg.sv
frame_gen/frame_serializer.sv
frame_gen/frame_sequencer.sv
axi_wr/axi_burst_writer.sv
hw/eth_stim_top.sv
tb/tb_eth_stim_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the eth_stim_gen testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/1ps \
	--top-module tb_eth_stim_top \
	--Mdir obj_dir \
	-o sim_eth_stim \
	-f eth_stim_gen.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim_eth_stim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation failed with status $sim_status"
	exit $sim_status
fi

exit 0
